/* source/ising_ctrl_pkg.sv */
/*
 * Control types for the configuration sequencer:
 * the cycle and transfer count type and the timing register bundle.
 */

package ising_ctrl_pkg;

    // cycle counts and address step counts
    typedef logic [15:0] counter_t;

    // timing settings, loaded together by cfg_load_i
    typedef struct packed {
        // cycles each word line is held
        counter_t cycle_per_dt_write;
        // address steps, J rows plus one for h
        counter_t trans_num;
    } cfg_timing_t;

endpackage

/* source/ising_data_pkg.sv */
/*
 * Coefficient types and size defaults:
 * the signed weight type, its width, and default array dimensions.
 */

package ising_data_pkg;

    // one J or h coefficient, two's complement
    typedef logic signed [3:0] weight_t;

    localparam int BIT_DATA = $bits(weight_t);

    // default array size for the top level
    localparam int NUM_SPIN_DEFAULT = 8;
    localparam int PARALLELISM_DEFAULT = 2;

endpackage

/* source/step_counter.sv */
/*
 * Loadable wrapping counter with a single-cycle overflow flag.
 */

`timescale 1ns/1ps

module step_counter (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     load_i,
    input  ising_ctrl_pkg::counter_t d_i,
    input  logic                     recount_i,
    input  logic                     step_i,
    output ising_ctrl_pkg::counter_t q_o,
    output logic                     overflow_o
);
    import ising_ctrl_pkg::*;

    counter_t limit_q;
    counter_t count_q;
    logic     at_last;

    assign at_last = (count_q == limit_q - counter_t'(1));
    assign overflow_o = step_i & at_last;
    assign q_o = count_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            limit_q <= '0;
        end else if (load_i) begin
            limit_q <= d_i;
        end
    end

    // wraps on the step that reaches limit minus one
    always_ff @(posedge clk_i) begin
        if (rst_i || recount_i) begin
            count_q <= '0;
        end else if (step_i) begin
            count_q <= at_last ? '0 : count_q + counter_t'(1);
        end
    end

endmodule

/* source/coeff_store.sv */
/*
 * Coefficient store: J row memory with per-slice host writes,
 * the h register, and registered read ports for the sequencer.
 */

`timescale 1ns/1ps

module coeff_store #(
    parameter int num_spin    = ising_data_pkg::NUM_SPIN_DEFAULT,
    parameter int parallelism = ising_data_pkg::PARALLELISM_DEFAULT
) (
    input  logic                                                  clk_i,
    input  logic                                                  rst_i,
    // host write port
    input  logic                                                  wr_valid_i,
    output logic                                                  wr_ready_o,
    input  logic [$clog2(num_spin+1)-1:0]                         wr_addr_i,
    input  logic [num_spin*ising_data_pkg::BIT_DATA-1:0]          wr_data_i,
    input  logic                                                  busy_i,
    // sequencer read ports
    input  logic                                                  j_ren_i,
    input  logic [$clog2(num_spin/parallelism)-1:0]               j_raddr_i,
    output logic [parallelism*num_spin*ising_data_pkg::BIT_DATA-1:0] j_rdata_o,
    input  logic                                                  h_ren_i,
    output logic [num_spin*ising_data_pkg::BIT_DATA-1:0]          h_rdata_o
);
    import ising_data_pkg::*;

    localparam int ROWS  = num_spin / parallelism;
    localparam int J_AW  = $clog2(ROWS);
    localparam int SEL_W = (parallelism > 1) ? $clog2(parallelism) : 1;
    localparam int ROW_W = num_spin * BIT_DATA;
    localparam int WR_AW = $clog2(num_spin + 1);

    logic [parallelism*ROW_W-1:0] j_mem [ROWS];
    logic [ROW_W-1:0]             h_q;

    logic             wr_fire;
    logic             wr_is_j;
    logic             wr_is_h;
    logic [J_AW-1:0]  wr_row;
    logic [SEL_W-1:0] wr_slice;

    // host may only write while the sequencer is idle
    assign wr_ready_o = ~busy_i;
    assign wr_fire = wr_valid_i & wr_ready_o;

    assign wr_is_j = (wr_addr_i < WR_AW'(num_spin));
    assign wr_is_h = (wr_addr_i == WR_AW'(num_spin));
    assign wr_row = J_AW'(wr_addr_i / parallelism);
    assign wr_slice = SEL_W'(wr_addr_i % parallelism);

    // slice s of a row sits at bits [s*ROW_W +: ROW_W]
    always_ff @(posedge clk_i) begin
        if (wr_fire && wr_is_j) begin
            for (int s = 0; s < parallelism; s++) begin
                if (wr_slice == SEL_W'(s)) begin
                    j_mem[wr_row][s*ROW_W +: ROW_W] <= wr_data_i;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire && wr_is_h) begin
            h_q <= wr_data_i;
        end
    end

    // read data valid the cycle after the strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            j_rdata_o <= '0;
            h_rdata_o <= '0;
        end else begin
            if (j_ren_i) begin
                j_rdata_o <= j_mem[j_raddr_i];
            end
            if (h_ren_i) begin
                h_rdata_o <= h_q;
            end
        end
    end

endmodule

/* source/analog_cfg.sv */
/*
 * Configuration sequencer: walks the J rows slice by slice, then h,
 * and drives the write word lines and bit lines of the analog array.
 */

`timescale 1ns/1ps

module analog_cfg #(
    parameter int num_spin    = ising_data_pkg::NUM_SPIN_DEFAULT,
    parameter int parallelism = ising_data_pkg::PARALLELISM_DEFAULT
) (
    input  logic                                                  clk_i,
    input  logic                                                  rst_i,
    input  logic                                                  cfg_load_i,
    input  ising_ctrl_pkg::cfg_timing_t                           cfg_timing_i,
    input  logic                                                  start_i,
    // coefficient store reads
    output logic                                                  j_ren_o,
    output logic [$clog2(num_spin/parallelism)-1:0]               j_raddr_o,
    input  logic [parallelism*num_spin*ising_data_pkg::BIT_DATA-1:0] j_rdata_i,
    output logic                                                  h_ren_o,
    input  logic [num_spin*ising_data_pkg::BIT_DATA-1:0]          h_rdata_i,
    // analog array
    output logic [num_spin-1:0]                                   j_wwl_o,
    output logic                                                  h_wwl_o,
    output logic [num_spin*ising_data_pkg::BIT_DATA-1:0]          wbl_o,
    // status
    output logic                                                  busy_o,
    output logic                                                  idle_o
);
    import ising_ctrl_pkg::*;
    import ising_data_pkg::*;

    localparam int ROWS  = num_spin / parallelism;
    localparam int J_AW  = $clog2(ROWS);
    localparam int SEL_W = (parallelism > 1) ? $clog2(parallelism) : 1;
    localparam int IDX_W = $clog2(num_spin);
    localparam int ROW_W = num_spin * BIT_DATA;
    // h follows the last J row
    localparam counter_t H_ADDR = counter_t'(ROWS);

    logic             busy_q;
    logic             launch;
    counter_t         delay_q;
    counter_t         addr_q;
    logic             delay_ovf;
    logic             addr_ovf;
    logic             addr_step;
    logic             at_h;
    logic [SEL_W-1:0] sel_q;
    logic             last_slice;

    // read strobes delayed to meet the returning data
    logic             j_ren_q;
    logic             h_ren_q;
    logic [SEL_W-1:0] rd_sel_q;
    logic [IDX_W-1:0] rd_idx_q;
    logic [1:0]       ovf_pipe_q;
    logic [ROW_W-1:0] wbl_nxt;
    logic [num_spin-1:0] wl_onehot;

    assign launch = start_i & idle_o;
    assign at_h = (addr_q == H_ADDR);
    assign last_slice = (sel_q == SEL_W'(parallelism - 1));
    assign addr_step = delay_ovf & (last_slice | at_h);

    assign j_ren_o = busy_q & ~at_h & (delay_q == '0);
    assign h_ren_o = busy_q & at_h & (delay_q == '0);
    assign j_raddr_o = addr_q[J_AW-1:0];

    // idle only once the last word line has dropped
    assign idle_o = ~busy_q & ~j_ren_q & ~h_ren_q & ~h_wwl_o & ~(|j_wwl_o);
    assign busy_o = ~idle_o;

    assign wbl_nxt = h_ren_q ? h_rdata_i : j_rdata_i[rd_sel_q*ROW_W +: ROW_W];

    always_comb begin
        wl_onehot = '0;
        wl_onehot[rd_idx_q] = 1'b1;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
        end else if (launch) begin
            busy_q <= 1'b1;
        end else if (addr_ovf) begin
            busy_q <= 1'b0;
        end
    end

    // slice within the current J row
    always_ff @(posedge clk_i) begin
        if (rst_i || launch) begin
            sel_q <= '0;
        end else if (delay_ovf && !at_h) begin
            sel_q <= last_slice ? '0 : sel_q + SEL_W'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            j_ren_q    <= 1'b0;
            h_ren_q    <= 1'b0;
            ovf_pipe_q <= '0;
        end else begin
            j_ren_q    <= j_ren_o;
            h_ren_q    <= h_ren_o;
            ovf_pipe_q <= {ovf_pipe_q[0], delay_ovf};
        end
    end

    // word line target, captured with the strobe
    always_ff @(posedge clk_i) begin
        if (j_ren_o) begin
            rd_sel_q <= sel_q;
            rd_idx_q <= IDX_W'(int'(j_raddr_o) * parallelism + int'(sel_q));
        end
    end

    // a new transfer takes priority over the end of the previous one
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            j_wwl_o <= '0;
            h_wwl_o <= 1'b0;
            wbl_o   <= '0;
        end else if (j_ren_q || h_ren_q) begin
            j_wwl_o <= j_ren_q ? wl_onehot : '0;
            h_wwl_o <= h_ren_q;
            wbl_o   <= wbl_nxt;
        end else if (ovf_pipe_q[1]) begin
            j_wwl_o <= '0;
            h_wwl_o <= 1'b0;
            wbl_o   <= '0;
        end
    end

    // hold time of each transfer
    step_counter u_step_counter_delay (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .load_i     (cfg_load_i),
        .d_i        (cfg_timing_i.cycle_per_dt_write),
        .recount_i  (launch),
        .step_i     (busy_q),
        .q_o        (delay_q),
        .overflow_o (delay_ovf)
    );

    // row address, h last
    step_counter u_step_counter_addr (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .load_i     (cfg_load_i),
        .d_i        (cfg_timing_i.trans_num),
        .recount_i  (launch),
        .step_i     (addr_step),
        .q_o        (addr_q),
        .overflow_o (addr_ovf)
    );

endmodule

/* source/ising_cfg_top.sv */
/*
 * Top level of the coefficient loading path:
 * coefficient store and configuration sequencer.
 */

`timescale 1ns/1ps

module ising_cfg_top #(
    parameter int num_spin    = ising_data_pkg::NUM_SPIN_DEFAULT,
    parameter int parallelism = ising_data_pkg::PARALLELISM_DEFAULT
) (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic                                         cfg_load_i,
    input  ising_ctrl_pkg::cfg_timing_t                  cfg_timing_i,
    input  logic                                         start_i,
    input  logic                                         wr_valid_i,
    output logic                                         wr_ready_o,
    input  logic [$clog2(num_spin+1)-1:0]                wr_addr_i,
    input  logic [num_spin*ising_data_pkg::BIT_DATA-1:0] wr_data_i,
    output logic [num_spin-1:0]                          j_wwl_o,
    output logic                                         h_wwl_o,
    output logic [num_spin*ising_data_pkg::BIT_DATA-1:0] wbl_o,
    output logic                                         idle_o
);
    import ising_data_pkg::*;

    localparam int ROW_W = num_spin * BIT_DATA;
    localparam int J_AW  = $clog2(num_spin / parallelism);

    logic                         busy;
    logic                         j_ren;
    logic [J_AW-1:0]              j_raddr;
    logic [parallelism*ROW_W-1:0] j_rdata;
    logic                         h_ren;
    logic [ROW_W-1:0]             h_rdata;

    coeff_store #(
        .num_spin    (num_spin),
        .parallelism (parallelism)
    ) u_coeff_store (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wr_valid_i (wr_valid_i),
        .wr_ready_o (wr_ready_o),
        .wr_addr_i  (wr_addr_i),
        .wr_data_i  (wr_data_i),
        .busy_i     (busy),
        .j_ren_i    (j_ren),
        .j_raddr_i  (j_raddr),
        .j_rdata_o  (j_rdata),
        .h_ren_i    (h_ren),
        .h_rdata_o  (h_rdata)
    );

    analog_cfg #(
        .num_spin    (num_spin),
        .parallelism (parallelism)
    ) u_analog_cfg (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cfg_load_i   (cfg_load_i),
        .cfg_timing_i (cfg_timing_i),
        .start_i      (start_i),
        .j_ren_o      (j_ren),
        .j_raddr_o    (j_raddr),
        .j_rdata_i    (j_rdata),
        .h_ren_o      (h_ren),
        .h_rdata_i    (h_rdata),
        .j_wwl_o      (j_wwl_o),
        .h_wwl_o      (h_wwl_o),
        .wbl_o        (wbl_o),
        .busy_o       (busy),
        .idle_o       (idle_o)
    );

endmodule

/* test/tb_ising_cfg.sv */
/*
 * Testbench for the coefficient loading path: host writes with random
 * gaps, two configuration runs, word-line pulse monitor and final report.
 */

`timescale 1ns/1ps

module tb_ising_cfg;
    import ising_ctrl_pkg::*;
    import ising_data_pkg::*;

    localparam int NUM_SPIN    = 8;
    localparam int PARALLELISM = 2;
    localparam int ROW_W       = NUM_SPIN * BIT_DATA;
    localparam int ADDR_W      = $clog2(NUM_SPIN + 1);
    localparam int NUM_ADDR    = NUM_SPIN + 1;
    // J rows plus one step for h
    localparam int TRANS_NUM   = NUM_SPIN / PARALLELISM + 1;
    localparam int MAX_HOLD    = 5;
    localparam int WRITE_SLOT  = 5;
    localparam int TIMEOUT_CYCLES = 4 * (NUM_ADDR * MAX_HOLD + NUM_ADDR * WRITE_SLOT);

    logic               clk_i;
    logic               rst_i;
    logic               cfg_load_i;
    cfg_timing_t        cfg_timing_i;
    logic               start_i;
    logic               wr_valid_i;
    logic               wr_ready_o;
    logic [ADDR_W-1:0]  wr_addr_i;
    logic [ROW_W-1:0]   wr_data_i;
    logic [NUM_SPIN-1:0] j_wwl_o;
    logic               h_wwl_o;
    logic [ROW_W-1:0]   wbl_o;
    logic               idle_o;

    logic [31:0] pattern_mem [0:2*NUM_ADDR+1];
    logic [31:0] rng_state;
    int          mismatch_count;
    int          failure_count;
    int          cycle_count;

    // pulse monitor state
    // word line vector is {h, j}
    logic [NUM_ADDR-1:0] wl_now;
    logic [NUM_ADDR-1:0] prev_wl;
    int                  cur_len;
    logic [ROW_W-1:0]    cur_wbl;
    logic [NUM_ADDR-1:0] pulse_wl_q[$];
    int                  pulse_len_q[$];
    logic [ROW_W-1:0]    pulse_wbl_q[$];

    ising_cfg_top #(
        .num_spin    (NUM_SPIN),
        .parallelism (PARALLELISM)
    ) UUT (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cfg_load_i   (cfg_load_i),
        .cfg_timing_i (cfg_timing_i),
        .start_i      (start_i),
        .wr_valid_i   (wr_valid_i),
        .wr_ready_o   (wr_ready_o),
        .wr_addr_i    (wr_addr_i),
        .wr_data_i    (wr_data_i),
        .j_wwl_o      (j_wwl_o),
        .h_wwl_o      (h_wwl_o),
        .wbl_o        (wbl_o),
        .idle_o       (idle_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("MISMATCH at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
        mismatch_count++;
    endtask

    // holds the request until the store accepts it
    task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [ROW_W-1:0] data);
        logic accepted;
        accepted = 1'b0;
        @(posedge clk_i);
        wr_valid_i <= 1'b1;
        wr_addr_i  <= addr;
        wr_data_i  <= data;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = (wr_ready_o === 1'b1);
            @(posedge clk_i);
        end
        wr_valid_i <= 1'b0;
    endtask

    // closes a pulse whenever the active word line changes
    always @(negedge clk_i) begin
        if (rst_i) begin
            prev_wl = '0;
            cur_len = 0;
        end else begin
            wl_now = {h_wwl_o, j_wwl_o};
            if (wl_now != prev_wl) begin
                if (prev_wl != '0) begin
                    pulse_wl_q.push_back(prev_wl);
                    pulse_len_q.push_back(cur_len);
                    pulse_wbl_q.push_back(cur_wbl);
                end
                cur_len = 1;
                cur_wbl = wbl_o;
            end else if (wl_now != '0) begin
                cur_len++;
                if (wbl_o !== cur_wbl) begin
                    report_mismatch("wbl_o", cur_wbl, wbl_o);
                end
            end
            if (wl_now != '0 && wr_ready_o !== 1'b0) begin
                report_mismatch("wr_ready_o", 0, wr_ready_o);
            end
            prev_wl = wl_now;
        end
    end

    task automatic run_sequence(input logic [15:0] hold, input bit try_write);
        int n;
        @(posedge clk_i);
        cfg_load_i <= 1'b1;
        cfg_timing_i.cycle_per_dt_write <= hold;
        cfg_timing_i.trans_num <= counter_t'(TRANS_NUM);
        @(posedge clk_i);
        cfg_load_i <= 1'b0;
        pulse_wl_q.delete();
        pulse_len_q.delete();
        pulse_wbl_q.delete();
        start_i <= 1'b1;
        @(posedge clk_i);
        start_i <= 1'b0;
        @(negedge clk_i);
        if (idle_o !== 1'b0) begin
            $display("ERROR at %0t ns: sequencer still idle after start", $time);
            failure_count++;
        end
        // a write during the run must be held off
        if (try_write) begin
            @(posedge clk_i);
            wr_valid_i <= 1'b1;
            wr_addr_i  <= ADDR_W'(3);
            wr_data_i  <= ~pattern_mem[2 + 2*3];
            repeat (4) begin
                @(negedge clk_i);
                if (wr_ready_o !== 1'b0) begin
                    report_mismatch("wr_ready_o", 0, wr_ready_o);
                end
            end
            @(posedge clk_i);
            wr_valid_i <= 1'b0;
        end
        do @(negedge clk_i); while (idle_o !== 1'b1);
        @(negedge clk_i);
        n = pulse_wl_q.size();
        if (n != NUM_ADDR) begin
            $display("ERROR at %0t ns: expected %0d word-line pulses, saw %0d",
                     $time, NUM_ADDR, n);
            failure_count++;
        end
        for (int k = 0; k < NUM_ADDR && k < n; k++) begin
            if ($countones(pulse_wl_q[k]) != 1) begin
                $display("ERROR at %0t ns: pulse %0d has %0d word lines active",
                         $time, k, $countones(pulse_wl_q[k]));
                failure_count++;
            end
            if (pulse_wl_q[k] != (NUM_ADDR'(1) << k)) begin
                report_mismatch($sformatf("{h_wwl_o,j_wwl_o} pulse %0d", k),
                                NUM_ADDR'(1) << k, pulse_wl_q[k]);
            end
            if (pulse_len_q[k] != int'(hold)) begin
                report_mismatch($sformatf("pulse length %0d", k), hold, pulse_len_q[k]);
            end
            if (pulse_wbl_q[k] !== pattern_mem[3 + 2*k]) begin
                report_mismatch($sformatf("wbl_o pulse %0d", k),
                                pattern_mem[3 + 2*k], pulse_wbl_q[k]);
            end
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("ERROR: timeout after %0d cycles, run did not finish", cycle_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst_i = 1'b1;
        cfg_load_i = 1'b0;
        cfg_timing_i = '0;
        start_i = 1'b0;
        wr_valid_i = 1'b0;
        wr_addr_i = '0;
        wr_data_i = '0;
        rng_state = 32'h2399;
        mismatch_count = 0;
        failure_count = 0;
        $readmemh("test/cfg_patterns.mem", pattern_mem);
        if ($isunknown(pattern_mem[2*NUM_ADDR+1])) begin
            $display("ERROR: pattern file test/cfg_patterns.mem is missing or short");
            failure_count++;
        end
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        if (idle_o !== 1'b1) report_mismatch("idle_o", 1, idle_o);
        if (wr_ready_o !== 1'b1) report_mismatch("wr_ready_o", 1, wr_ready_o);
        if (j_wwl_o !== '0) report_mismatch("j_wwl_o", 0, j_wwl_o);
        if (h_wwl_o !== 1'b0) report_mismatch("h_wwl_o", 0, h_wwl_o);
        if (wbl_o !== '0) report_mismatch("wbl_o", 0, wbl_o);
        // all J slices and h with random idle gaps
        for (int a = 0; a < NUM_ADDR; a++) begin
            rng_state = xorshift32(rng_state);
            repeat (rng_state % 4) @(posedge clk_i);
            host_write(ADDR_W'(a), pattern_mem[2 + 2*a]);
        end
        run_sequence(pattern_mem[0][15:0], 1'b1);
        run_sequence(pattern_mem[1][15:0], 1'b0);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
source/ising_ctrl_pkg.sv
source/ising_data_pkg.sv
source/step_counter.sv
source/coeff_store.sv
source/analog_cfg.sv
source/ising_cfg_top.sv
test/tb_ising_cfg.sv

/* Makefile */
# Verilator lint and simulation of the coefficient loading path

VERILATOR = verilator
FLAGS     = --timing -Wall -Wno-fatal
TOP       = tb_ising_cfg
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/cfg_patterns.mem */
// entries 0 and 1: word-line hold length in cycles for the two runs
// then one line per host address 0..8 (8 is h): write data, expected wbl_o
00000003
00000005
// J spin rows 0..7
1f2e3d4c 1f2e3d4c
80706050 80706050
a5b4c3d2 a5b4c3d2
0f1e2d3c 0f1e2d3c
76543210 76543210
fedcba98 fedcba98
13579bdf 13579bdf
2468ace0 2468ace0
// h vector
9e8d7c6b 9e8d7c6b
